//--- decode_pkg.sv
/*
 * decode package
 * opcode map, instruction formats and the decoded operation bundle
 * shared by the RV64I decode front end
 */
package decode_pkg;

    localparam int XLEN       = 64; // data and address width
    localparam int MAX_OPID_W = 8;  // room for clog2(ROB_SIZE)+1 id bits

    // major opcodes, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        OP_IMM    = 5'b00100,
        AUIPC     = 5'b00101,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        OP        = 5'b01100,
        LUI       = 5'b01101,
        OP_32     = 5'b01110,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
        logic [1:0] quad;  // 2'b11 for 32-bit encodings
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
        logic [1:0]  quad;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
        logic [1:0] quad;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
        logic [1:0] quad;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
        logic [1:0]  quad;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
        logic [1:0] quad;
    } j_fmt_t;

    // one instruction word seen through every base format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } insn_t;

    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_LSU
    } fu_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, BR, JUMP, INV
    } alu_op_t;

    typedef struct packed {
        fu_t                   fu;
        alu_op_t               alu_op;
        logic                  word;     // 32-bit result, sign extended
        logic                  load;
        logic                  store;
        logic [2:0]            mem_bits; // access size and sign
        logic [2:0]            br_cond;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic                  use_rs1;
        logic                  use_rs2;
        logic                  use_rd;
        logic                  use_imm;  // second alu operand is imm, not rs2
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [MAX_OPID_W-1:0] opid;
    } dec_op_t;

endpackage

//--- imm_gen.sv
/*
 * immediate generator
 * picks the immediate layout of the instruction format and sign-extends it
 */
module imm_gen (
    input  decode_pkg::insn_t   ir,
    input  decode_pkg::opcode_t opcode,
    output logic [63:0]         imm
);
    import decode_pkg::*;

    always_comb begin
        case (opcode)
            LOAD, OP_IMM, OP_IMM_32, JALR: begin // I type
                imm = {{52{ir.i_fmt.imm_11_0[11]}}, ir.i_fmt.imm_11_0};
            end
            STORE: begin // S type
                imm = {{52{ir.s_fmt.imm_11_5[6]}}, ir.s_fmt.imm_11_5, ir.s_fmt.imm_4_0};
            end
            BRANCH: begin // B type, even offset
                imm = {{51{ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                       ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};
            end
            LUI, AUIPC: begin // U type, upper 20 bits
                imm = {{32{ir.u_fmt.imm_31_12[19]}}, ir.u_fmt.imm_31_12, 12'd0};
            end
            JAL: begin // J type
                imm = {{43{ir.j_fmt.imm_20}}, ir.j_fmt.imm_20, ir.j_fmt.imm_19_12,
                       ir.j_fmt.imm_11, ir.j_fmt.imm_10_1, 1'b0};
            end
            default: imm = '0; // R type and unknown opcodes
        endcase
    end

endmodule

//--- insn_decoder.sv
/*
 * instruction decoder
 * turns one RV64I word into a decoded operation; anything outside
 * the base integer set comes out as an invalid ALU operation
 */
module insn_decoder (
    input  decode_pkg::insn_t   ir,
    input  logic [63:0]         pc,
    output decode_pkg::dec_op_t op
);
    import decode_pkg::*;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [5:0]  funct6; // shift-immediate on RV64 has a 6-bit shamt
    logic [63:0] imm;
    logic        legal;

    assign funct3 = ir.r_fmt.funct3;
    assign funct7 = ir.r_fmt.funct7;
    assign funct6 = ir.r_fmt.funct7[6:1];

    imm_gen u_imm_gen (
        .ir     (ir),
        .opcode (ir.r_fmt.opcode),
        .imm    (imm)
    );

    // integer function from funct3, alt selects SUB/SRA
    function automatic alu_op_t int_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  int_op = alt ? SUB : ADD;
            3'b001:  int_op = SLL;
            3'b010:  int_op = SLT;
            3'b011:  int_op = SLTU;
            3'b100:  int_op = XOR;
            3'b101:  int_op = alt ? SRA : SRL;
            3'b110:  int_op = OR;
            default: int_op = AND;
        endcase
    endfunction

    always_comb begin
        legal     = 1'b0;
        op        = '0;
        op.fu     = FU_NONE;
        op.alu_op = INV;
        case (ir.r_fmt.opcode)
            LOAD: begin
                legal       = funct3 != 3'b111; // no 128-bit or ldu
                op.fu       = FU_LSU;
                op.alu_op   = ADD;              // address generation
                op.load     = 1'b1;
                op.mem_bits = funct3;
                op.use_rs1  = 1'b1;
                op.use_rd   = 1'b1;
                op.use_imm  = 1'b1;
            end
            STORE: begin
                legal       = ~funct3[2];       // sb, sh, sw, sd
                op.fu       = FU_LSU;
                op.alu_op   = ADD;
                op.store    = 1'b1;
                op.mem_bits = funct3;
                op.use_rs1  = 1'b1;
                op.use_rs2  = 1'b1;
                op.use_imm  = 1'b1;
            end
            OP_IMM: begin
                legal = funct3 == 3'b001 ? funct6 == 6'd0 :
                        funct3 == 3'b101 ? funct6 == 6'd0 || funct6 == 6'b010000 : 1'b1;
                op.fu      = FU_ALU;
                op.alu_op  = int_op(funct3, funct3 == 3'b101 && funct6[4]);
                op.use_rs1 = 1'b1;
                op.use_rd  = 1'b1;
                op.use_imm = 1'b1;
            end
            OP_IMM_32: begin
                legal = funct3 == 3'b000 ||
                        funct3 == 3'b001 && funct7 == 7'd0 ||
                        funct3 == 3'b101 && (funct7 == 7'd0 || funct7 == 7'b0100000);
                op.fu      = FU_ALU;
                op.alu_op  = int_op(funct3, funct3 == 3'b101 && funct7[5]);
                op.word    = 1'b1;
                op.use_rs1 = 1'b1;
                op.use_rd  = 1'b1;
                op.use_imm = 1'b1;
            end
            OP, OP_32: begin
                legal = funct7 == 7'd0 ||
                        funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101);
                if (ir.r_fmt.opcode == OP_32) begin
                    legal   = legal && (funct3 == 3'b000 || funct3 == 3'b001 ||
                                        funct3 == 3'b101);
                    op.word = 1'b1;
                end
                op.fu      = FU_ALU;
                op.alu_op  = int_op(funct3, funct7[5]);
                op.use_rs1 = 1'b1;
                op.use_rs2 = 1'b1;
                op.use_rd  = 1'b1;
            end
            LUI, AUIPC: begin // pc operand for auipc is implied
                legal      = 1'b1;
                op.fu      = FU_ALU;
                op.alu_op  = ADD;
                op.use_rd  = 1'b1;
                op.use_imm = 1'b1;
            end
            JAL, JALR: begin
                legal      = ir.r_fmt.opcode == JAL || funct3 == 3'b000;
                op.fu      = FU_ALU;
                op.alu_op  = JUMP;
                op.use_rs1 = ir.r_fmt.opcode == JALR;
                op.use_rd  = 1'b1;
            end
            BRANCH: begin
                legal      = funct3[2:1] != 2'b01;
                op.fu      = FU_ALU;
                op.alu_op  = BR;
                op.br_cond = funct3;
                op.use_rs1 = 1'b1;
                op.use_rs2 = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        op.rs1 = op.use_rs1 ? ir.r_fmt.rs1 : 5'd0;
        op.rs2 = op.use_rs2 ? ir.r_fmt.rs2 : 5'd0;
        op.rd  = op.use_rd  ? ir.r_fmt.rd  : 5'd0;
        op.imm = imm;

        // compressed or reserved encodings and unkept opcodes
        if (!legal || ir.r_fmt.quad != 2'b11) begin
            op        = '0;
            op.fu     = FU_ALU;
            op.alu_op = INV;
        end
        op.pc = pc;
    end

endmodule

//--- id_alloc.sv
/*
 * operation ID allocator
 * head and tail pointers over a ROB-sized ID space with one wrap bit
 */
module id_alloc #(
    parameter int ROB_SIZE     = 16,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0] commit_count,
    input  logic                              redir_valid,
    input  logic [$clog2(ROB_SIZE):0]         redir_opid,
    output logic [$clog2(ROB_SIZE):0]         next_opid,
    output logic                              has_room
);
    localparam int ID_W = $clog2(ROB_SIZE) + 1;

    logic [ID_W-1:0] head;  // oldest id in flight
    logic [ID_W-1:0] tail;  // next id to hand out
    logic [ID_W-1:0] count; // ids in flight

    assign count     = tail - head; // wraps cleanly through the extra bit
    assign has_room  = count < ID_W'(ROB_SIZE);
    assign next_opid = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else begin
            head <= head + ID_W'(commit_count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
        end else if (redir_valid) begin
            tail <= redir_opid + ID_W'(1); // younger ids are dropped
        end else if (alloc) begin
            tail <= tail + ID_W'(1);
        end
    end

endmodule

//--- decode_queue.sv
/*
 * decode queue
 * circular buffer of decoded operations between decode and rename,
 * emptied in one edge by a redirect
 */
module decode_queue #(
    parameter int DQ_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  decode_pkg::dec_op_t wr_op,
    input  logic                flush,
    input  logic                rd_ready,
    output logic                full,
    output logic                rd_valid,
    output decode_pkg::dec_op_t rd_op
);
    import decode_pkg::*;

    localparam int PTR_W = $clog2(DQ_DEPTH);

    dec_op_t          mem [DQ_DEPTH];
    logic [PTR_W-1:0] front;  // oldest entry
    logic [PTR_W:0]   count;
    logic [PTR_W-1:0] wr_idx;
    logic             rd_fire;

    assign wr_idx   = front + count[PTR_W-1:0];
    assign full     = count == (PTR_W + 1)'(DQ_DEPTH);
    assign rd_valid = count != '0 && !flush; // nothing leaves while redirecting
    assign rd_op    = mem[front];
    assign rd_fire  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            count <= '0;
        end else begin
            if (rd_fire) begin
                front <= front + PTR_W'(1);
            end
            count <= count + (PTR_W + 1)'(wr_en) - (PTR_W + 1)'(rd_fire);
        end
    end

endmodule

//--- decode_stage.sv
/*
 * decode stage top
 * decodes the fetched word, stamps it with the next operation ID and
 * queues it for rename
 */
module decode_stage #(
    parameter int ROB_SIZE     = 16,
    parameter int DQ_DEPTH     = 4,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetch_valid,
    input  logic [63:0]                       fetch_pc,
    input  decode_pkg::insn_t                 fetch_ir,
    output logic                              fetch_ready,
    output logic                              dec_valid,
    input  logic                              dec_ready,
    output decode_pkg::dec_op_t               dec_op,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0] commit_count,
    input  logic                              redir_valid,
    input  logic [$clog2(ROB_SIZE):0]         redir_opid
);
    import decode_pkg::*;

    dec_op_t                  raw_op;
    dec_op_t                  wr_op;
    logic                     accept;
    logic                     q_full;
    logic                     has_room;
    logic [$clog2(ROB_SIZE):0] next_opid;

    assign fetch_ready = !q_full && has_room && !redir_valid;
    assign accept      = fetch_valid && fetch_ready;

    always_comb begin
        wr_op      = raw_op;
        wr_op.opid = MAX_OPID_W'(next_opid); // stamp id at enqueue
    end

    insn_decoder u_decoder (
        .ir (fetch_ir),
        .pc (fetch_pc),
        .op (raw_op)
    );

    id_alloc #(
        .ROB_SIZE     (ROB_SIZE),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_id_alloc (
        .clk          (clk),
        .rst          (rst),
        .alloc        (accept),
        .commit_count (commit_count),
        .redir_valid  (redir_valid),
        .redir_opid   (redir_opid),
        .next_opid    (next_opid),
        .has_room     (has_room)
    );

    decode_queue #(
        .DQ_DEPTH (DQ_DEPTH)
    ) u_queue (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (accept),
        .wr_op    (wr_op),
        .flush    (redir_valid),
        .rd_ready (dec_ready),
        .full     (q_full),
        .rd_valid (dec_valid),
        .rd_op    (dec_op)
    );

endmodule

//--- tb_clock.sv
/*
 * testbench clock
 * free-running clock for the decode stage testbench
 */
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk; // half period high, half low

endmodule

//--- decode_stage_assertions.sv
/*
 * decode stage assertions
 * handshake and reset rules checked on the decode stage ports
 */
module decode_stage_assertions (
    input logic                clk,
    input logic                rst,
    input logic                fetch_ready,
    input logic                dec_valid,
    input logic                dec_ready,
    input decode_pkg::dec_op_t dec_op,
    input logic                redir_valid
);

    int fail_count = 0; // failed assertions, read by the testbench

    idle_after_reset: assert property (@(posedge clk) rst |=> !dec_valid)
        else begin
            $error("dec_valid high in the cycle after reset");
            fail_count++;
        end

    idle_on_redirect: assert property (@(posedge clk) disable iff (rst)
        redir_valid |-> !dec_valid)
        else begin
            $error("dec_valid high during a redirect");
            fail_count++;
        end

    // head entry holds while rename stalls
    op_held: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> $stable(dec_op))
        else begin
            $error("dec_op changed while stalled");
            fail_count++;
        end

    no_fetch_on_redirect: assert property (@(posedge clk) disable iff (rst)
        redir_valid |-> !fetch_ready)
        else begin
            $error("fetch_ready high during a redirect");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .fetch_ready (fetch_ready),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_op      (dec_op),
    .redir_valid (redir_valid)
);

//--- decode_stage_tb.sv
/*
 * decode stage testbench
 * random fetch, rename, commit and redirect traffic checked against
 * a reference decoder and a model of the ID space and decode queue
 */
module decode_stage_tb;
    import decode_pkg::*;

    localparam int ROB_SIZE     = 8;
    localparam int DQ_DEPTH     = 4;
    localparam int COMMIT_WIDTH = 2;
    localparam int ID_W         = $clog2(ROB_SIZE) + 1;
    localparam int CC_W         = $clog2(COMMIT_WIDTH + 1);
    localparam int N_TRANS      = 3000;
    localparam int MAX_CYCLES   = N_TRANS * 4;

    logic            clk;
    logic            rst;
    logic            fetch_valid;
    logic [63:0]     fetch_pc;
    insn_t           fetch_ir;
    logic            fetch_ready;
    logic            dec_valid;
    logic            dec_ready;
    dec_op_t         dec_op;
    logic [CC_W-1:0] commit_count;
    logic            redir_valid;
    logic [ID_W-1:0] redir_opid;

    logic [31:0]     lfsr = 32'h5cfc_5203;
    dec_op_t         sb [$];    // ops expected in the decode queue
    logic [ID_W-1:0] head = '0; // model of the ID pointers
    logic [ID_W-1:0] tail = '0;
    int              renamed = 0; // dequeued, not yet committed
    int              n_deq = 0;
    int              cycles = 0;
    opcode_t         kept_ops [11] = '{LOAD, STORE, OP_IMM, OP_IMM_32, OP, OP_32,
                                       LUI, AUIPC, JAL, JALR, BRANCH};

    tb_clock #(.PERIOD(100)) u_clock (.clk(clk));

    decode_stage #(
        .ROB_SIZE     (ROB_SIZE),
        .DQ_DEPTH     (DQ_DEPTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_ir     (fetch_ir),
        .fetch_ready  (fetch_ready),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_op       (dec_op),
        .commit_count (commit_count),
        .redir_valid  (redir_valid),
        .redir_opid   (redir_opid)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic alu_op_t int_alu(input logic [2:0] f3, input logic alt,
                                        input logic reg_form);
        alu_op_t r;
        case (f3)
            3'b000:  r = (alt && reg_form) ? SUB : ADD;
            3'b001:  r = SLL;
            3'b010:  r = SLT;
            3'b011:  r = SLTU;
            3'b100:  r = XOR;
            3'b101:  r = alt ? SRA : SRL;
            3'b110:  r = OR;
            default: r = AND;
        endcase
        return r;
    endfunction

    function automatic dec_op_t ref_decode(input logic [31:0] w, input logic [63:0] pc);
        dec_op_t    d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = w[14:12];
        f7 = w[31:25];
        d = '0;
        d.fu = FU_ALU;
        ok = 1'b0;
        case (w[6:2])
            LOAD, STORE: begin // w[5] set for stores
                ok = w[5] ? !f3[2] : f3 != 3'b111;
                d.fu = FU_LSU;
                d.alu_op = ADD;
                d.load = !w[5];
                d.store = w[5];
                d.mem_bits = f3;
                {d.use_rs1, d.use_rs2, d.use_rd, d.use_imm} = w[5] ? 4'b1101 : 4'b1011;
                d.imm = w[5] ? 64'($signed({w[31:25], w[11:7]})) : 64'($signed(w[31:20]));
            end
            OP_IMM, OP_IMM_32: begin
                if (w[3]) // 32-bit form
                    ok = f3 == 3'b000 || (f3[1:0] == 2'b01 && f7 == {1'b0, f3[2] & w[30], 5'b0});
                else
                    ok = f3[1:0] != 2'b01 || w[31:26] == {1'b0, f3[2] & w[30], 4'b0};
                d.alu_op = int_alu(f3, w[30], 1'b0);
                d.word = w[3];
                {d.use_rs1, d.use_rs2, d.use_rd, d.use_imm} = 4'b1011;
                d.imm = 64'($signed(w[31:20]));
            end
            OP, OP_32: begin
                ok = f7 == {1'b0, w[30] & (f3 == 3'b000 || f3 == 3'b101), 5'b0};
                if (w[3])
                    ok = ok && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101);
                d.alu_op = int_alu(f3, w[30], 1'b1);
                d.word = w[3];
                {d.use_rs1, d.use_rs2, d.use_rd, d.use_imm} = 4'b1110;
            end
            LUI, AUIPC: begin
                ok = 1'b1;
                d.alu_op = ADD;
                {d.use_rs1, d.use_rs2, d.use_rd, d.use_imm} = 4'b0011;
                d.imm = 64'($signed({w[31:12], 12'h000}));
            end
            JAL: begin
                ok = 1'b1;
                d.alu_op = JUMP;
                d.use_rd = 1'b1;
                d.imm = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            end
            JALR: begin
                ok = f3 == 3'b000;
                d.alu_op = JUMP;
                {d.use_rs1, d.use_rs2, d.use_rd, d.use_imm} = 4'b1010;
                d.imm = 64'($signed(w[31:20]));
            end
            BRANCH: begin
                ok = f3[2:1] != 2'b01;
                d.alu_op = BR;
                d.br_cond = f3;
                {d.use_rs1, d.use_rs2, d.use_rd, d.use_imm} = 4'b1100;
                d.imm = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            end
            default: ok = 1'b0;
        endcase
        d.rs1 = d.use_rs1 ? w[19:15] : 5'd0;
        d.rs2 = d.use_rs2 ? w[24:20] : 5'd0;
        d.rd  = d.use_rd ? w[11:7] : 5'd0;
        if (!ok || w[1:0] != 2'b11) begin // illegal, compressed or out of scope
            d = '0;
            d.fu = FU_ALU;
            d.alu_op = INV;
        end
        d.pc = pc;
        return d;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_op(input dec_op_t got, input dec_op_t exp);
        if (got !== exp)
            fail_now($sformatf("error dec_op: got %h, expected %h", got, exp));
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    // compare this cycle, then step the model through the coming edge
    task automatic score_cycle();
        logic    exp_ready;
        logic    exp_valid;
        dec_op_t op;
        if (DUT.u_assertions.fail_count != 0)
            fail_now("a bound assertion on the decode stage failed");
        exp_ready = sb.size() < DQ_DEPTH && ID_W'(tail - head) < ROB_SIZE && !redir_valid;
        exp_valid = sb.size() != 0 && !redir_valid;
        check_ready("fetch_ready", fetch_ready, exp_ready);
        check_ready("dec_valid", dec_valid, exp_valid);
        if (exp_valid) begin
            check_op(dec_op, sb[0]); // also holds it stable under stall
            if (dec_ready) begin
                void'(sb.pop_front());
                renamed++;
                n_deq++;
            end
        end
        head = head + ID_W'(commit_count);
        renamed -= int'(commit_count);
        if (fetch_valid && exp_ready) begin
            op = ref_decode(fetch_ir, fetch_pc);
            op.opid = MAX_OPID_W'(tail);
            sb.push_back(op);
            tail = tail + ID_W'(1);
        end
        if (redir_valid) begin // queue dropped and younger ids reused
            sb.delete();
            tail = redir_opid + ID_W'(1);
            renamed = int'(ID_W'(redir_opid - head)) + 1;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] w;
        logic [31:0] redir_pick;
        int          c;
        w = take_bits(32);
        if (take_bits(2) != 0) begin
            w[6:0] = {kept_ops[take_bits(4) % 11], 2'b11};
            if (take_bits(1) == 1)
                w[31:25] = {1'b0, w[30], 5'b0}; // legal funct7 more often
        end
        fetch_ir <= w;
        fetch_pc <= {take_bits(32), take_bits(32)};
        fetch_valid <= take_bits(4) < 11;
        dec_ready <= take_bits(4) < 11;
        redir_pick = take_bits(5);
        if (renamed > 0 && redir_pick == 0) begin
            redir_valid <= 1'b1;
            redir_opid <= ID_W'(int'(head) + int'(take_bits(3)) % renamed);
            commit_count <= '0;
        end else begin
            c = 0;
            if (take_bits(3) < 3) // retire in about 3 of 8 cycles so the ROB fills
                c = int'(take_bits(1)) + 1;
            if (c > renamed)
                c = renamed;
            redir_valid <= 1'b0;
            commit_count <= CC_W'(c);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles == MAX_CYCLES)
            fail_now($sformatf("timeout: fewer than %0d ops left decode in %0d cycles",
                               N_TRANS, MAX_CYCLES));
    end

    initial begin
        rst <= 1'b1;
        fetch_valid <= 1'b0;
        fetch_pc <= '0;
        fetch_ir <= '0;
        dec_ready <= 1'b0;
        commit_count <= '0;
        redir_valid <= 1'b0;
        redir_opid <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (n_deq < N_TRANS) begin
            @(negedge clk);
            score_cycle();
            @(posedge clk);
            drive_inputs();
        end
        @(negedge clk);
        if (DUT.u_assertions.fail_count != 0)
            fail_now("a bound assertion on the decode stage failed");
        else
            $display("Testbench passed");
        $finish;
    end

endmodule

//--- verilog.f
decode_pkg.sv
imm_gen.sv
insn_decoder.sv
id_alloc.sv
decode_queue.sv
decode_stage.sv
tb_clock.sv
decode_stage_assertions.sv
decode_stage_tb.sv
